/* rtl/rv_exec_pkg.sv */
// shared constants and types for the RV32I execution unit
// register map, opcodes, status bits and the ALU / branch operation enums
`default_nettype none

package rv_exec_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int apb_addr_w = 8;

    // APB register map, byte offsets
    localparam logic [apb_addr_w-1:0] addr_rs1     = 8'h00;
    localparam logic [apb_addr_w-1:0] addr_rs2     = 8'h04;
    localparam logic [apb_addr_w-1:0] addr_pc      = 8'h08;
    localparam logic [apb_addr_w-1:0] addr_inst    = 8'h0C;  // write launches
    localparam logic [apb_addr_w-1:0] addr_result  = 8'h10;  // read only
    localparam logic [apb_addr_w-1:0] addr_next_pc = 8'h14;  // read only
    localparam logic [apb_addr_w-1:0] addr_status  = 8'h18;  // read only

    // major opcodes kept from RV32I
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;

    localparam logic [6:0] funct7_base = 7'h00;
    localparam logic [6:0] funct7_alt  = 7'h20;  // SUB, SRA, SRAI

    // status word layout
    localparam int st_busy    = 0;
    localparam int st_illegal = 1;
    localparam int st_rd_we   = 2;
    localparam int st_rd      = 3;  // rd in bits 7..3
    localparam int st_taken   = 8;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b  // LUI, immediate straight through
    } alu_op_e;

    typedef enum logic [2:0] {
        bjp_none,
        bjp_jump,
        bjp_beq,
        bjp_bne,
        bjp_blt,
        bjp_bge,
        bjp_bltu,
        bjp_bgeu
    } bjp_op_e;

endpackage

`default_nettype wire

/* rtl/rv_exec_if.sv */
// pipeline interfaces: issue, decode to execute, execute to result
// all valid-only, the pipeline never stalls
`default_nettype none

interface issue_if;
    import rv_exec_pkg::*;

    logic            valid;  // one cycle per launched instruction
    logic [xlen-1:0] inst;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;

    modport source (output valid, inst, pc, rs1_val, rs2_val);
    modport sink (input valid, inst, pc, rs1_val, rs2_val);
    modport monitor (input valid);  // in-flight tracking only
endinterface

interface dec_exe_if;
    import rv_exec_pkg::*;

    logic                  valid;
    alu_op_e               alu_op;
    bjp_op_e               bjp_op;
    logic                  op1_pc;   // operand 1 is pc, not rs1
    logic                  op2_imm;  // operand 2 is imm, not rs2
    logic                  is_jalr;
    logic [xlen-1:0]       imm;
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       rs1_val;
    logic [xlen-1:0]       rs2_val;
    logic [reg_addr_w-1:0] rd;
    logic                  rd_we;
    logic                  illegal;

    modport source (output valid, alu_op, bjp_op, op1_pc, op2_imm, is_jalr, imm, pc,
                    rs1_val, rs2_val, rd, rd_we, illegal);
    modport sink (input valid, alu_op, bjp_op, op1_pc, op2_imm, is_jalr, imm, pc,
                  rs1_val, rs2_val, rd, rd_we, illegal);
endinterface

interface exe_res_if;
    import rv_exec_pkg::*;

    logic                  valid;
    logic [xlen-1:0]       result;
    logic [xlen-1:0]       next_pc;
    logic [reg_addr_w-1:0] rd;
    logic                  rd_we;
    logic                  taken;
    logic                  illegal;

    modport source (output valid, result, next_pc, rd, rd_we, taken, illegal);
    modport sink (input valid, result, next_pc, rd, rd_we, taken, illegal);
endinterface

`default_nettype wire

/* rtl/rv_apb_regs.sv */
// APB slave for the execution unit: operand registers, instruction launch
// and read-back of result, next pc and status; no wait states
`default_nettype none

module rv_apb_regs (
    input  logic                              clk,
    input  logic                              rst_i,
    input  logic                              psel_i,
    input  logic                              penable_i,
    input  logic                              pwrite_i,
    input  logic [rv_exec_pkg::apb_addr_w-1:0] paddr_i,
    input  logic [rv_exec_pkg::xlen-1:0]       pwdata_i,
    input  logic [rv_exec_pkg::xlen-1:0]       result_i,
    input  logic [rv_exec_pkg::xlen-1:0]       next_pc_i,
    input  logic [rv_exec_pkg::xlen-1:0]       status_i,
    output logic [rv_exec_pkg::xlen-1:0]       prdata_o,
    output logic                              pready_o,
    output logic                              pslverr_o,
    issue_if.source                           issue
);
    import rv_exec_pkg::*;

    logic [xlen-1:0] rs1_q;
    logic [xlen-1:0] rs2_q;
    logic [xlen-1:0] pc_q;
    logic [xlen-1:0] inst_q;
    logic            issue_q;
    logic            access;
    logic            mapped;
    logic            rd_only;
    logic            wr_en;

    assign access = psel_i & penable_i;

    // address decode and read mux
    always_comb begin
        mapped   = 1'b1;
        rd_only  = 1'b0;
        prdata_o = '0;
        case (paddr_i)
            addr_rs1:     prdata_o = rs1_q;
            addr_rs2:     prdata_o = rs2_q;
            addr_pc:      prdata_o = pc_q;
            addr_inst:    prdata_o = inst_q;  // last launched word
            addr_result: begin
                prdata_o = result_i;
                rd_only  = 1'b1;
            end
            addr_next_pc: begin
                prdata_o = next_pc_i;
                rd_only  = 1'b1;
            end
            addr_status: begin
                prdata_o = status_i;
                rd_only  = 1'b1;
            end
            default:      mapped = 1'b0;
        endcase
    end

    assign pready_o  = 1'b1;
    assign pslverr_o = access & (~mapped | (pwrite_i & rd_only));
    assign wr_en     = access & pwrite_i & mapped & ~rd_only;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            rs1_q   <= '0;
            rs2_q   <= '0;
            pc_q    <= '0;
            inst_q  <= '0;
            issue_q <= 1'b0;
        end else begin
            issue_q <= wr_en && (paddr_i == addr_inst);  // single-cycle pulse
            if (wr_en) begin
                case (paddr_i)
                    addr_rs1: rs1_q  <= pwdata_i;
                    addr_rs2: rs2_q  <= pwdata_i;
                    addr_pc:  pc_q   <= pwdata_i;
                    default:  inst_q <= pwdata_i;
                endcase
            end
        end
    end

    // operands are stable here, the next access phase is two cycles away
    assign issue.valid   = issue_q;
    assign issue.inst    = inst_q;
    assign issue.pc      = pc_q;
    assign issue.rs1_val = rs1_q;
    assign issue.rs2_val = rs2_q;

    a_penable_sel: assert property (@(posedge clk) disable iff (rst_i)
        penable_i |-> psel_i);

endmodule

`default_nettype wire

/* rtl/rv_decode.sv */
// decode stage: instruction fields, immediate select and operation mapping
// registered one cycle after issue
`default_nettype none

module rv_decode (
    input  logic       clk,
    input  logic       rst_i,
    issue_if.sink      issue,
    dec_exe_if.source  dex
);
    import rv_exec_pkg::*;

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       imm_u;
    logic [xlen-1:0]       imm_j;
    logic [xlen-1:0]       imm_i;
    logic [xlen-1:0]       imm_b;
    logic [xlen-1:0]       imm_sh;
    alu_op_e               alu_op;
    bjp_op_e               bjp_op;
    logic                  op1_pc;
    logic                  op2_imm;
    logic                  is_jalr;
    logic [xlen-1:0]       imm;
    logic                  writes_rd;
    logic                  illegal;
    logic                  alt_ok;

    assign opcode = issue.inst[6:0];
    assign funct3 = issue.inst[14:12];
    assign funct7 = issue.inst[31:25];
    assign rd     = issue.inst[11:7];

    assign imm_u  = {issue.inst[31:12], 12'b0};
    assign imm_j  = {{12{issue.inst[31]}}, issue.inst[19:12], issue.inst[20],
                     issue.inst[30:21], 1'b0};
    assign imm_i  = {{20{issue.inst[31]}}, issue.inst[31:20]};
    assign imm_b  = {{20{issue.inst[31]}}, issue.inst[7], issue.inst[30:25],
                     issue.inst[11:8], 1'b0};
    assign imm_sh = {27'b0, issue.inst[24:20]};

    // funct7 0x20 only legal for SUB and SRA/SRAI
    assign alt_ok = (funct7 == funct7_alt) && ((funct3 == 3'b000) || (funct3 == 3'b101));

    always_comb begin
        alu_op    = alu_add;
        bjp_op    = bjp_none;
        op1_pc    = 1'b0;
        op2_imm   = 1'b0;
        is_jalr   = 1'b0;
        imm       = imm_i;
        writes_rd = 1'b0;
        illegal   = 1'b0;
        case (opcode)
            opc_lui: begin
                alu_op    = alu_pass_b;
                op2_imm   = 1'b1;
                imm       = imm_u;
                writes_rd = 1'b1;
            end
            opc_auipc: begin
                op1_pc    = 1'b1;
                op2_imm   = 1'b1;
                imm       = imm_u;
                writes_rd = 1'b1;
            end
            opc_jal: begin
                bjp_op    = bjp_jump;
                imm       = imm_j;
                writes_rd = 1'b1;
            end
            opc_jalr: begin
                bjp_op    = bjp_jump;
                is_jalr   = 1'b1;
                writes_rd = 1'b1;
                illegal   = (funct3 != 3'b000);
            end
            opc_branch: begin
                imm = imm_b;
                case (funct3)
                    3'b000:  bjp_op = bjp_beq;
                    3'b001:  bjp_op = bjp_bne;
                    3'b100:  bjp_op = bjp_blt;
                    3'b101:  bjp_op = bjp_bge;
                    3'b110:  bjp_op = bjp_bltu;
                    3'b111:  bjp_op = bjp_bgeu;
                    default: illegal = 1'b1;  // 010, 011 unused
                endcase
            end
            opc_op_imm, opc_op: begin
                op2_imm   = (opcode == opc_op_imm);
                writes_rd = 1'b1;
                case (funct3)
                    3'b000:  alu_op = alu_add;
                    3'b001:  alu_op = alu_sll;
                    3'b010:  alu_op = alu_slt;
                    3'b011:  alu_op = alu_sltu;
                    3'b100:  alu_op = alu_xor;
                    3'b101:  alu_op = (funct7 == funct7_alt) ? alu_sra : alu_srl;
                    3'b110:  alu_op = alu_or;
                    default: alu_op = alu_and;
                endcase
                if (opcode == opc_op) begin
                    if (funct3 == 3'b000 && funct7 == funct7_alt)
                        alu_op = alu_sub;
                    illegal = (funct7 != funct7_base) && !alt_ok;
                end else if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    imm     = imm_sh;  // funct7 field checks the shamt too
                    illegal = (funct7 != funct7_base) && !alt_ok;
                end
            end
            default: illegal = 1'b1;  // loads, stores, system, M extension
        endcase
        if (illegal) begin
            alu_op    = alu_add;
            bjp_op    = bjp_none;
            writes_rd = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i)
            dex.valid <= 1'b0;
        else
            dex.valid <= issue.valid;
    end

    always_ff @(posedge clk) begin
        if (issue.valid) begin
            dex.alu_op  <= alu_op;
            dex.bjp_op  <= bjp_op;
            dex.op1_pc  <= op1_pc;
            dex.op2_imm <= op2_imm;
            dex.is_jalr <= is_jalr;
            dex.imm     <= imm;
            dex.pc      <= issue.pc;
            dex.rs1_val <= issue.rs1_val;
            dex.rs2_val <= issue.rs2_val;
            dex.rd      <= rd;
            dex.rd_we   <= writes_rd && (rd != '0);  // x0 never written
            dex.illegal <= illegal;
        end
    end

endmodule

`default_nettype wire

/* rtl/rv_execute.sv */
// execute stage: ALU, branch compare and next pc, registered
`default_nettype none

module rv_execute (
    input  logic       clk,
    input  logic       rst_i,
    dec_exe_if.sink    dex,
    exe_res_if.source  exr
);
    import rv_exec_pkg::*;

    logic [xlen-1:0] op1;
    logic [xlen-1:0] op2;
    logic [4:0]      shamt;
    logic [xlen-1:0] alu_res;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] pc_plus_imm;
    logic [xlen-1:0] jalr_tgt;
    logic            cond;
    logic [xlen-1:0] result;
    logic [xlen-1:0] next_pc;

    assign op1   = dex.op1_pc ? dex.pc : dex.rs1_val;
    assign op2   = dex.op2_imm ? dex.imm : dex.rs2_val;
    assign shamt = op2[4:0];

    always_comb begin
        case (dex.alu_op)
            alu_sub:    alu_res = op1 - op2;
            alu_sll:    alu_res = op1 << shamt;
            alu_slt:    alu_res = {{(xlen-1){1'b0}}, $signed(op1) < $signed(op2)};
            alu_sltu:   alu_res = {{(xlen-1){1'b0}}, op1 < op2};
            alu_xor:    alu_res = op1 ^ op2;
            alu_srl:    alu_res = op1 >> shamt;
            alu_sra:    alu_res = $unsigned($signed(op1) >>> shamt);
            alu_or:     alu_res = op1 | op2;
            alu_and:    alu_res = op1 & op2;
            alu_pass_b: alu_res = op2;
            default:    alu_res = op1 + op2;
        endcase
    end

    // branch condition, jumps always taken
    always_comb begin
        case (dex.bjp_op)
            bjp_jump: cond = 1'b1;
            bjp_beq:  cond = dex.rs1_val == dex.rs2_val;
            bjp_bne:  cond = dex.rs1_val != dex.rs2_val;
            bjp_blt:  cond = $signed(dex.rs1_val) < $signed(dex.rs2_val);
            bjp_bge:  cond = $signed(dex.rs1_val) >= $signed(dex.rs2_val);
            bjp_bltu: cond = dex.rs1_val < dex.rs2_val;
            bjp_bgeu: cond = dex.rs1_val >= dex.rs2_val;
            default:  cond = 1'b0;
        endcase
    end

    assign pc_plus4    = dex.pc + 32'd4;
    assign pc_plus_imm = dex.pc + dex.imm;
    assign jalr_tgt    = (dex.rs1_val + dex.imm) & ~32'd1;

    always_comb begin
        result  = '0;  // branches and illegal give zero
        next_pc = pc_plus4;
        if (dex.bjp_op == bjp_jump) begin
            result  = pc_plus4;  // link address
            next_pc = dex.is_jalr ? jalr_tgt : pc_plus_imm;
        end else if (cond) begin
            next_pc = pc_plus_imm;
        end else if (!dex.illegal && dex.bjp_op == bjp_none) begin
            result = alu_res;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i)
            exr.valid <= 1'b0;
        else
            exr.valid <= dex.valid;
    end

    always_ff @(posedge clk) begin
        if (dex.valid) begin
            exr.result  <= result;
            exr.next_pc <= next_pc;
            exr.rd      <= dex.rd;
            exr.rd_we   <= dex.rd_we;
            exr.taken   <= cond;
            exr.illegal <= dex.illegal;
        end
    end

    a_taken_even: assert property (@(posedge clk) disable iff (rst_i)
        exr.valid && exr.taken |-> !exr.next_pc[0]);

endmodule

`default_nettype wire

/* rtl/rv_result.sv */
// result stage: holds result, next pc and status for the host
// the in-flight counter drives the busy bit
`default_nettype none

module rv_result (
    input  logic                        clk,
    input  logic                        rst_i,
    issue_if.monitor                    issue,
    exe_res_if.sink                     exr,
    output logic [rv_exec_pkg::xlen-1:0] result_o,
    output logic [rv_exec_pkg::xlen-1:0] next_pc_o,
    output logic [rv_exec_pkg::xlen-1:0] status_o
);
    import rv_exec_pkg::*;

    logic [1:0]            in_flight;  // at most two
    logic                  illegal_q;
    logic                  rd_we_q;
    logic [reg_addr_w-1:0] rd_q;
    logic                  taken_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            in_flight <= '0;
            result_o  <= '0;
            next_pc_o <= '0;
            illegal_q <= 1'b0;
            rd_we_q   <= 1'b0;
            rd_q      <= '0;
            taken_q   <= 1'b0;
        end else begin
            case ({issue.valid, exr.valid})
                2'b10:   in_flight <= in_flight + 2'd1;
                2'b01:   in_flight <= in_flight - 2'd1;
                default: in_flight <= in_flight;  // none, or one in and one out
            endcase
            if (exr.valid) begin
                result_o  <= exr.result;
                next_pc_o <= exr.next_pc;
                illegal_q <= exr.illegal;
                rd_we_q   <= exr.rd_we;
                rd_q      <= exr.rd;
                taken_q   <= exr.taken;
            end
        end
    end

    always_comb begin
        status_o                          = '0;
        status_o[st_busy]                 = (in_flight != 2'd0);
        status_o[st_illegal]              = illegal_q;
        status_o[st_rd_we]                = rd_we_q;
        status_o[st_rd +: reg_addr_w]     = rd_q;
        status_o[st_taken]                = taken_q;
    end

    // every completion was counted in at issue
    a_done_counted: assert property (@(posedge clk) disable iff (rst_i)
        exr.valid |-> in_flight != 2'd0);

endmodule

`default_nettype wire

/* rtl/rv_exec_top.sv */
// top level of the RV32I execution unit behind an APB slave port
// decode, execute and result stages in a three-cycle pipeline
`default_nettype none

module rv_exec_top (
    input  logic                              clk,
    input  logic                              rst_i,
    input  logic                              psel_i,
    input  logic                              penable_i,
    input  logic                              pwrite_i,
    input  logic [rv_exec_pkg::apb_addr_w-1:0] paddr_i,
    input  logic [rv_exec_pkg::xlen-1:0]       pwdata_i,
    output logic [rv_exec_pkg::xlen-1:0]       prdata_o,
    output logic                              pready_o,
    output logic                              pslverr_o
);
    import rv_exec_pkg::*;

    logic [xlen-1:0] result;
    logic [xlen-1:0] next_pc;
    logic [xlen-1:0] status;

    issue_if   issue ();
    dec_exe_if dex ();
    exe_res_if exr ();

    rv_apb_regs u_regs (
        .clk       (clk),
        .rst_i     (rst_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .result_i  (result),
        .next_pc_i (next_pc),
        .status_i  (status),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .issue     (issue.source)
    );

    rv_decode u_decode (
        .clk   (clk),
        .rst_i (rst_i),
        .issue (issue.sink),
        .dex   (dex.source)
    );

    rv_execute u_execute (
        .clk   (clk),
        .rst_i (rst_i),
        .dex   (dex.sink),
        .exr   (exr.source)
    );

    rv_result u_result (
        .clk       (clk),
        .rst_i     (rst_i),
        .issue     (issue.monitor),
        .exr       (exr.sink),
        .result_o  (result),
        .next_pc_o (next_pc),
        .status_o  (status)
    );

endmodule

`default_nettype wire

/* verif/tb_rv_exec_table.svh */
// instruction table for the execution unit testbench, one row per launch
// rows with rnd set take rs1/rs2 from the LFSR and compute the result
`ifndef TB_RV_EXEC_TABLE_SVH
`define TB_RV_EXEC_TABLE_SVH

typedef struct packed {
    logic [31:0] inst;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [31:0] pc;
    logic [31:0] exp_result;
    logic [31:0] exp_next_pc;
    logic [31:0] exp_status;  // busy bit left out, always 0 once idle
    logic        rnd;
} vec_t;

localparam int n_vec = 32;

// columns: inst, rs1, rs2, pc, result, next pc, status, random operands
localparam vec_t vec_table [n_vec] = '{
    '{'h002082B3, 'h1234, 'h111, 'h100, 'h1345, 'h104, 'h2C, 1'b0},         // add
    '{'h402082B3, 'h0, 'h0, 'h104, 'h0, 'h108, 'h2C, 1'b1},                 // sub
    '{'h4020D2B3, 'h0, 'h0, 'h108, 'h0, 'h10C, 'h2C, 1'b1},                 // sra
    '{'h0020B2B3, 'h0, 'h0, 'h10C, 'h0, 'h110, 'h2C, 1'b1},                 // sltu
    '{'h0020A2B3, 'hFFFFFFFF, 'h1, 'h110, 'h1, 'h114, 'h2C, 1'b0},          // slt
    '{'h0020C2B3, 'hF0F0F0F0, 'hFF00FF00, 'h114, 'h0FF00FF0, 'h118, 'h2C, 1'b0},
    '{'h00709293, 'h0, 'h0, 'h118, 'h0, 'h11C, 'h2C, 1'b1},                 // slli 7
    '{'h40D0D293, 'h0, 'h0, 'h11C, 'h0, 'h120, 'h2C, 1'b1},                 // srai 13
    '{'hFFF08293, 'h10, 'h0, 'h120, 'hF, 'h124, 'h2C, 1'b0},                // addi -1
    '{'h0F00F293, 'h12345678, 'h0, 'h124, 'h70, 'h128, 'h2C, 1'b0},         // andi
    '{'h123452B7, 'h0, 'h0, 'h200, 'h12345000, 'h204, 'h2C, 1'b0},          // lui
    '{'h00001297, 'h0, 'h0, 'h200, 'h1200, 'h204, 'h2C, 1'b0},              // auipc
    '{'h00208033, 'h1, 'h2, 'h200, 'h3, 'h204, 'h0, 1'b0},                  // add x0
    // branch offset field lands in rd bits of status
    '{'h00208863, 'h5, 'h5, 'h300, 'h0, 'h310, 'h180, 1'b0},                // beq
    '{'h00208863, 'h5, 'h6, 'h300, 'h0, 'h304, 'h80, 1'b0},
    '{'h00209863, 'h5, 'h6, 'h300, 'h0, 'h310, 'h180, 1'b0},                // bne
    '{'h00209863, 'h7, 'h7, 'h300, 'h0, 'h304, 'h80, 1'b0},
    '{'h0020C863, 'hFFFFFFFE, 'h1, 'h300, 'h0, 'h310, 'h180, 1'b0},         // blt
    '{'h0020C863, 'h1, 'hFFFFFFFE, 'h300, 'h0, 'h304, 'h80, 1'b0},
    '{'h0020D863, 'h1, 'hFFFFFFFE, 'h300, 'h0, 'h310, 'h180, 1'b0},         // bge
    '{'h0020D863, 'hFFFFFFFE, 'h1, 'h300, 'h0, 'h304, 'h80, 1'b0},
    '{'h0020E863, 'h1, 'hFFFFFFFE, 'h300, 'h0, 'h310, 'h180, 1'b0},         // bltu
    '{'h0020E863, 'hFFFFFFFE, 'h1, 'h300, 'h0, 'h304, 'h80, 1'b0},
    '{'h0020F863, 'hFFFFFFFE, 'h1, 'h300, 'h0, 'h310, 'h180, 1'b0},         // bgeu
    '{'h0020F863, 'h1, 'hFFFFFFFE, 'h300, 'h0, 'h304, 'h80, 1'b0},
    '{'hFE209CE3, 'h1, 'h2, 'h300, 'h0, 'h2F8, 'h1C8, 1'b0},                // bne -8
    '{'h100002EF, 'h0, 'h0, 'h400, 'h404, 'h500, 'h12C, 1'b0},              // jal
    '{'h003082E7, 'h1000, 'h0, 'h400, 'h404, 'h1002, 'h12C, 1'b0},          // jalr 3
    '{'h0000A283, 'h1, 'h2, 'h500, 'h0, 'h504, 'h2A, 1'b0},                 // lw
    '{'h022082B3, 'h3, 'h4, 'h500, 'h0, 'h504, 'h2A, 1'b0},                 // mul
    '{'h300092F3, 'h1, 'h0, 'h500, 'h0, 'h504, 'h2A, 1'b0},                 // csrrw
    '{'h02709293, 'h1, 'h0, 'h500, 'h0, 'h504, 'h2A, 1'b0}                  // slli f7 1
};

`endif

/* verif/tb_rv_exec.sv */
// testbench for the RV32I execution unit, launches the table rows over APB
// and checks result, next pc and status, then APB errors and back-to-back issue
`default_nettype none

module tb_rv_exec;
    timeunit 1ns;
    timeprecision 100ps;

    import rv_exec_pkg::*;

    logic        clk;
    logic        rst_i;
    logic        psel_i;
    logic        penable_i;
    logic        pwrite_i;
    logic [7:0]  paddr_i;
    logic [31:0] pwdata_i;
    logic [31:0] prdata_o;
    logic        pready_o;
    logic        pslverr_o;
    logic [15:0] lfsr;
    int          n_pass;
    int          n_fail;

    `include "tb_rv_exec_table.svh"

    rv_exec_top UUT (
        .clk       (clk),
        .rst_i     (rst_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o)
    );

    always #4 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_word(output logic [31:0] w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr = lfsr_next(lfsr);
            w    = {w[30:0], lfsr[0]};  // one step per bit
        end
    endtask

    // RV32I result of an OP or OP-IMM instruction
    function automatic logic [31:0] expect_alu(input logic [31:0] inst, input logic [31:0] a,
                                               input logic [31:0] b);
        logic [31:0] opnd;
        logic [4:0]  sh;
        logic        alt;
        opnd = (inst[6:0] == 7'h13) ? {{20{inst[31]}}, inst[31:20]} : b;
        sh   = opnd[4:0];
        alt  = inst[30];
        case (inst[14:12])
            3'd0:    expect_alu = (alt && inst[6:0] == 7'h33) ? a - opnd : a + opnd;
            3'd1:    expect_alu = a << sh;
            3'd2:    expect_alu = {31'b0, $signed(a) < $signed(opnd)};
            3'd3:    expect_alu = {31'b0, a < opnd};
            3'd4:    expect_alu = a ^ opnd;
            3'd5:    expect_alu = alt ? (a >> sh) | ({32{a[31]}} & ~(32'hFFFFFFFF >> sh))
                                      : a >> sh;
            3'd6:    expect_alu = a | opnd;
            default: expect_alu = a & opnd;
        endcase
    endfunction

    // called 1 ns after a rising edge, returns at the same point
    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic err);
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = 1'b1;
        paddr_i   = addr;
        pwdata_i  = data;
        @(posedge clk);
        #1 penable_i = 1'b1;
        #3 err = pslverr_o;  // mid access cycle
        @(posedge clk);
        #1;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = addr;
        @(posedge clk);
        #1 penable_i = 1'b1;
        #3;
        data = prdata_o;
        err  = pslverr_o;
        @(posedge clk);
        #1;
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    // poll STATUS until busy drops
    task automatic wait_idle(output bit ok);
        logic [31:0] st;
        logic        err;
        ok = 1'b0;
        for (int n = 0; n < 20; n++) begin
            apb_read(addr_status, st, err);
            if (!st[st_busy]) begin
                ok = 1'b1;
                break;
            end
        end
    endtask

    task automatic report_test(input string name, input bit pass);
        $display("%s: %s", name, pass ? "pass" : "fail");
        if (pass)
            n_pass++;
        else
            n_fail++;
    endtask

    task automatic check_reset_state();
        logic [31:0] st;
        logic        err;
        bit          pass;
        pass = 1'b1;
        apb_read(addr_status, st, err);
        if (st !== 32'h0) begin
            $display("Fail reset: status got %h expected %h", st, 32'h0);
            pass = 1'b0;
        end
        if (err) begin
            $display("reset: PSLVERR raised on a read of STATUS");
            pass = 1'b0;
        end
        if (pready_o !== 1'b1) begin
            $display("Fail reset: pready_o got %h expected %h", pready_o, 1'b1);
            pass = 1'b0;
        end
        report_test("reset state", pass);
    endtask

    task automatic run_row(input int idx);
        vec_t        v;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] exp_res;
        logic [31:0] result;
        logic [31:0] next_pc;
        logic [31:0] status;
        logic        err;
        logic        any_err;
        bit          ok;
        bit          pass;
        v       = vec_table[idx];
        rs1     = v.rs1;
        rs2     = v.rs2;
        exp_res = v.exp_result;
        pass    = 1'b1;
        if (v.rnd) begin
            draw_word(rs1);
            draw_word(rs2);
            exp_res = expect_alu(v.inst, rs1, rs2);
        end
        apb_write(addr_rs1, rs1, err);
        any_err = err;
        apb_write(addr_rs2, rs2, err);
        any_err = any_err | err;
        apb_write(addr_pc, v.pc, err);
        any_err = any_err | err;
        apb_write(addr_inst, v.inst, err);
        any_err = any_err | err;
        wait_idle(ok);
        apb_read(addr_result, result, err);
        any_err = any_err | err;
        apb_read(addr_next_pc, next_pc, err);
        any_err = any_err | err;
        apb_read(addr_status, status, err);
        any_err = any_err | err;
        if (any_err) begin
            $display("row %0d: PSLVERR raised on a mapped register", idx);
            pass = 1'b0;
        end
        if (!ok) begin
            $display("row %0d: busy did not clear within 20 status reads", idx);
            pass = 1'b0;
        end
        if (result !== exp_res) begin
            $display("Fail row %0d: result got %h expected %h", idx, result, exp_res);
            pass = 1'b0;
        end
        if (next_pc !== v.exp_next_pc) begin
            $display("Fail row %0d: next_pc got %h expected %h", idx, next_pc, v.exp_next_pc);
            pass = 1'b0;
        end
        if (status !== v.exp_status) begin
            $display("Fail row %0d: status got %h expected %h", idx, status, v.exp_status);
            pass = 1'b0;
        end
        report_test($sformatf("row %0d inst %h", idx, v.inst), pass);
    endtask

    task automatic check_apb_errors();
        logic [31:0] res_before;
        logic [31:0] rs1_before;
        logic [31:0] val;
        logic        err;
        bit          pass;
        pass = 1'b1;
        apb_read(addr_result, res_before, err);
        apb_read(addr_rs1, rs1_before, err);
        apb_write(addr_result, ~res_before, err);
        if (!err) begin
            $display("apb: write to RESULT did not raise PSLVERR");
            pass = 1'b0;
        end
        apb_read(8'h40, val, err);
        if (!err) begin
            $display("apb: read of offset 0x40 did not raise PSLVERR");
            pass = 1'b0;
        end
        apb_read(addr_result, val, err);
        if (val !== res_before) begin
            $display("Fail apb: result got %h expected %h", val, res_before);
            pass = 1'b0;
        end
        apb_read(addr_rs1, val, err);
        if (val !== rs1_before) begin
            $display("Fail apb: rs1 got %h expected %h", val, rs1_before);
            pass = 1'b0;
        end
        report_test("apb errors", pass);
    endtask

    // add x5 then lui x10 with no gap, status must show the lui
    task automatic check_back_to_back();
        logic [31:0] result;
        logic [31:0] status;
        logic        err;
        bit          ok;
        bit          pass;
        pass = 1'b1;
        apb_write(addr_rs1, 32'h10, err);
        apb_write(addr_rs2, 32'h20, err);
        apb_write(addr_pc, 32'h600, err);
        apb_write(addr_inst, 32'h002082B3, err);
        apb_write(addr_inst, 32'hABCDE537, err);
        wait_idle(ok);
        if (!ok) begin
            $display("back to back: busy did not clear within 20 status reads");
            pass = 1'b0;
        end
        apb_read(addr_result, result, err);
        apb_read(addr_status, status, err);
        if (result !== 32'hABCDE000) begin
            $display("Fail back to back: result got %h expected %h", result, 32'hABCDE000);
            pass = 1'b0;
        end
        if (status !== 32'h54) begin
            $display("Fail back to back: status got %h expected %h", status, 32'h54);
            pass = 1'b0;
        end
        report_test("back to back", pass);
    endtask

    initial begin
        clk       = 1'b0;
        rst_i     = 1'b1;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = '0;
        pwdata_i  = '0;
        lfsr      = 16'd16;
        n_pass    = 0;
        n_fail    = 0;
        repeat (5) @(posedge clk);
        #1 rst_i = 1'b0;
        check_reset_state();
        for (int i = 0; i < n_vec; i++)
            run_row(i);
        check_apb_errors();
        check_back_to_back();
        $display("%0d tests, %0d passed, %0d failed", n_pass + n_fail, n_pass, n_fail);
        if (n_fail == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+verif
rtl/rv_exec_pkg.sv
rtl/rv_exec_if.sv
rtl/rv_apb_regs.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_result.sv
rtl/rv_exec_top.sv
verif/tb_rv_exec.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_rv_exec
FLIST     ?= flist.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Test OK"

clean:
	rm -rf obj_dir
